/* all.f */
+incdir+bench
design/fft_pkg.sv
design/bfly_if.sv
design/fft_sample_ram.sv
design/fft_twiddle_rom.sv
design/fft_butterfly.sv
design/fft_addr_ctrl.sv
design/fft_core.sv
bench/tb_fft_core.sv

/* Bender.yml */
package:
  name: fft_core

sources:
  - files:
      - design/fft_pkg.sv
      - design/bfly_if.sv
      - design/fft_sample_ram.sv
      - design/fft_twiddle_rom.sv
      - design/fft_butterfly.sv
      - design/fft_addr_ctrl.sv
      - design/fft_core.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_fft_core.sv

/* bench/fft_tb_tasks.svh */
`ifndef FFT_TB_TASKS_SVH
`define FFT_TB_TASKS_SVH
`default_nettype none

// --------------------
// random numbers
// --------------------
// galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
endfunction

// one lfsr step per bit taken
function automatic int unsigned random_bits(input int width);
    int unsigned bits;
    bits = 0;
    for (int i = 0; i < width; i++) begin
        bits = {bits[30:0], lfsr_state[0]};
        lfsr_state = lfsr_step(lfsr_state);
    end
    return bits;
endfunction

function automatic logic signed [fft_pkg::DATA_W-1:0] round_part(input real v);
    return fft_pkg::DATA_W'($rtoi($floor(v + 0.5)));
endfunction

// --------------------
// reference model
// --------------------
// X[k] = sum of x[n] * exp(-j*2*pi*k*n/N), divided by N
task automatic reference_dft();
    real acc_re;
    real acc_im;
    real ang;
    for (int k = 0; k < fft_pkg::N; k++) begin
        acc_re = 0.0;
        acc_im = 0.0;
        for (int n = 0; n < fft_pkg::N; n++) begin
            ang = 2.0 * PI * k * n / fft_pkg::N;
            acc_re += stim[n].re * $cos(ang) + stim[n].im * $sin(ang);
            acc_im += stim[n].im * $cos(ang) - stim[n].re * $sin(ang);
        end
        exp_spec[k].re = round_part(acc_re / fft_pkg::N);
        exp_spec[k].im = round_part(acc_im / fft_pkg::N);
    end
endtask

// --------------------
// compare tasks
// --------------------
task automatic check_sample(input string name, input fft_pkg::sample_t got,
                            input fft_pkg::sample_t want, input int tol);
    int diff_re;
    int diff_im;
    diff_re = int'(got.re) - int'(want.re);
    diff_im = int'(got.im) - int'(want.im);
    if (diff_re > tol || diff_re < -tol) begin
        errors++;
        $display("** Error at %0t: %s.re = %0d, expected %0d", $time, name, got.re, want.re);
    end
    if (diff_im > tol || diff_im < -tol) begin
        errors++;
        $display("** Error at %0t: %s.im = %0d, expected %0d", $time, name, got.im, want.im);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
        errors++;
        $display("** Error at %0t: %s = %b, expected %b", $time, name, got, want);
    end
endtask

// --------------------
// frame transfer
// --------------------
task automatic send_frame();
    for (int i = 0; i < fft_pkg::N; i++) begin
        in_valid = 1'b1;
        in_re    = stim[i].re;
        in_im    = stim[i].im;
        while (!in_ready) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        // transfer on the coming edge
        @(posedge clk);
        #DRIVE_DELAY;
    end
    in_valid = 1'b0;
    check_flag("busy", busy, 1'b1);
    check_flag("in_ready", in_ready, 1'b0);
endtask

// outputs are sampled where they are stable, one drive delay after the edge
task automatic recv_frame(input int tol, input bit stall);
    fft_pkg::sample_t got;
    fft_pkg::sample_t held;
    bit holding;
    int idx;
    idx     = 0;
    holding = 1'b0;
    while (idx < fft_pkg::N) begin
        out_ready = stall ? (random_bits(2) != 0) : 1'b1;
        got.re    = out_re;
        got.im    = out_im;
        if (holding) begin
            check_flag("out_valid", out_valid, 1'b1);
            check_sample("held output", got, held, 0);
        end
        if (out_valid && out_ready) begin
            check_sample($sformatf("out[%0d]", idx), got, exp_spec[idx], tol);
            check_flag("out_last", out_last, idx == fft_pkg::N - 1);
            check_flag("busy", busy, 1'b1);
            idx++;
            holding = 1'b0;
        end else if (out_valid) begin
            held    = got;
            holding = 1'b1;
        end
        @(posedge clk);
        #DRIVE_DELAY;
    end
    out_ready = 1'b0;
    // core is back in load after out_last
    check_flag("busy", busy, 1'b0);
    check_flag("in_ready", in_ready, 1'b1);
endtask

// --------------------
// directed tests
// --------------------
task automatic reset_values();
    check_flag("in_ready", in_ready, 1'b1);
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("busy", busy, 1'b0);
endtask

// every b operand is zero, so all bins are exact
task automatic impulse_response();
    for (int n = 0; n < fft_pkg::N; n++) begin
        stim[n] = '0;
    end
    stim[0].re = 16'sd1600;
    reference_dft();
    send_frame();
    recv_frame(0, 1'b0);
endtask

// only exact twiddles meet nonzero data
task automatic dc_response();
    for (int n = 0; n < fft_pkg::N; n++) begin
        stim[n].re = -16'sd800;
        stim[n].im = 16'sd320;
    end
    reference_dft();
    send_frame();
    recv_frame(0, 1'b0);
endtask

task automatic tone_response();
    for (int n = 0; n < fft_pkg::N; n++) begin
        stim[n].re = round_part(8000.0 * $cos(2.0 * PI * 3 * n / fft_pkg::N));
        stim[n].im = round_part(8000.0 * $sin(2.0 * PI * 3 * n / fft_pkg::N));
    end
    reference_dft();
    send_frame();
    recv_frame(TOL, 1'b0);
endtask

// two random frames back to back, parts within +-2000
task automatic stalled_random_frames();
    for (int f = 0; f < 2; f++) begin
        for (int n = 0; n < fft_pkg::N; n++) begin
            stim[n].re = fft_pkg::DATA_W'(int'(random_bits(12) % 4001) - 2000);
            stim[n].im = fft_pkg::DATA_W'(int'(random_bits(12) % 4001) - 2000);
        end
        reference_dft();
        send_frame();
        recv_frame(TOL, 1'b1);
    end
endtask

`default_nettype wire
`endif

/* bench/tb_fft_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fft_core;

    localparam int  CLK_PERIOD   = 100;
    localparam int  DRIVE_DELAY  = 10;
    localparam int  RESET_CYCLES = 4;
    localparam int  TOL          = 3;
    // watchdog budget
    localparam int  FRAMES       = 6;
    localparam int  FRAME_CYCLES = 200;
    localparam real PI           = 3.14159265358979;

    logic                               clk;
    logic                               rst_n;
    logic                               in_valid;
    logic                               in_ready;
    logic signed [fft_pkg::DATA_W-1:0]  in_re;
    logic signed [fft_pkg::DATA_W-1:0]  in_im;
    logic                               out_valid;
    logic                               out_ready;
    logic signed [fft_pkg::DATA_W-1:0]  out_re;
    logic signed [fft_pkg::DATA_W-1:0]  out_im;
    logic                               out_last;
    logic                               busy;

    int                                 errors;
    logic [31:0]                        lfsr_state;
    fft_pkg::sample_t                   stim [fft_pkg::N];
    fft_pkg::sample_t                   exp_spec [fft_pkg::N];

    fft_core fft_core_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_re     (in_re),
        .in_im     (in_im),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_re    (out_re),
        .out_im    (out_im),
        .out_last  (out_last),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------
    // watchdog
    // --------------------
    initial begin
        #(FRAMES * FRAME_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the DUT stopped answering a handshake");
        $display("Finished with errors");
        $finish;
    end

    // --------------------
    // test sequence
    // --------------------
    initial begin
        errors     = 0;
        lfsr_state = 32'h254b_6f18;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_re      = '0;
        in_im      = '0;
        out_ready  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;

        reset_values();
        impulse_response();
        dc_response();
        tone_response();
        stalled_random_frames();

        $display("%0d errors counted", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    `include "fft_tb_tasks.svh"

endmodule

`default_nettype wire

/* design/fft_core.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_core (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    output logic                                in_ready,
    input  logic signed [fft_pkg::DATA_W-1:0]   in_re,
    input  logic signed [fft_pkg::DATA_W-1:0]   in_im,
    output logic                                out_valid,
    input  logic                                out_ready,
    output logic signed [fft_pkg::DATA_W-1:0]   out_re,
    output logic signed [fft_pkg::DATA_W-1:0]   out_im,
    output logic                                out_last,
    output logic                                busy
);

    bfly_if bus ();

    fft_pkg::sample_t               in_data;
    fft_pkg::sample_t               out_data;
    logic                           load_en;
    logic [fft_pkg::ADDR_W-1:0]     load_addr;
    fft_pkg::sample_t               load_data;

    assign in_data.re = in_re;
    assign in_data.im = in_im;
    assign out_re     = out_data.re;
    assign out_im     = out_data.im;

    fft_addr_ctrl ctrl_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .port      (bus.ctrl),
        .data_a    (bus.data_a),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .busy      (busy)
    );

    fft_sample_ram ram_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .port      (bus.ram),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    fft_butterfly bfly_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .port  (bus.bfly)
    );

endmodule

`default_nettype wire

/* design/fft_addr_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_addr_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    bfly_if.ctrl                        port,
    input  fft_pkg::sample_t            data_a,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  fft_pkg::sample_t            in_data,
    output logic                        out_valid,
    input  logic                        out_ready,
    output fft_pkg::sample_t            out_data,
    output logic                        out_last,
    output logic                        load_en,
    output logic [fft_pkg::ADDR_W-1:0]  load_addr,
    output fft_pkg::sample_t            load_data,
    output logic                        busy
);

    typedef enum logic [2:0] {
        LOAD,
        STAGE_ISSUE,
        STAGE_DRAIN,
        UNLOAD_READ,
        UNLOAD_HOLD
    } state_t;

    state_t                         state;
    logic [fft_pkg::ADDR_W-1:0]     cnt;
    logic [fft_pkg::STAGE_W-1:0]    stage;
    logic [fft_pkg::TW_IDX_W-1:0]   group;
    logic [fft_pkg::TW_IDX_W-1:0]   offset;
    logic [1:0]                     drain_cnt;

    logic [fft_pkg::ADDR_W-1:0]     span;
    logic [fft_pkg::ADDR_W-1:0]     issue_a;
    logic [fft_pkg::ADDR_W-1:0]     issue_b;
    logic                           offset_last;
    logic                           stage_last;
    logic                           cnt_last;

    // --------------------
    // butterfly addressing
    // --------------------
    assign span        = fft_pkg::ADDR_W'(1) << stage;
    assign issue_a     = (fft_pkg::ADDR_W'(group) << (stage + 1'b1)) | fft_pkg::ADDR_W'(offset);
    assign issue_b     = issue_a + span;
    assign offset_last = (fft_pkg::ADDR_W'(offset) == span - 1'b1);
    // only the last butterfly of a stage touches the top address
    assign stage_last  = (issue_b == fft_pkg::ADDR_W'(fft_pkg::N - 1));
    assign cnt_last    = (cnt == fft_pkg::ADDR_W'(fft_pkg::N - 1));

    assign port.rd_en  = (state == STAGE_ISSUE) || (state == UNLOAD_READ);
    // unload reads one word, so both ports point at it
    assign port.addr_a = (state == UNLOAD_READ) ? cnt : issue_a;
    assign port.addr_b = (state == UNLOAD_READ) ? cnt : issue_b;
    assign port.tw_idx = offset << (fft_pkg::STAGE_W'(fft_pkg::LOG2N - 1) - stage);

    // --------------------
    // load and unload handshakes
    // --------------------
    assign in_ready  = (state == LOAD);
    assign load_en   = in_valid && in_ready;
    assign load_data = in_data;

    // bit-reversed write address, so the spectrum comes out in natural order
    always_comb begin
        for (int i = 0; i < fft_pkg::ADDR_W; i++) begin
            load_addr[i] = cnt[fft_pkg::ADDR_W-1-i];
        end
    end

    // sample comes straight from the registered read port, held while waiting
    assign out_valid = (state == UNLOAD_HOLD);
    assign out_data  = data_a;
    assign busy      = (state != LOAD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= LOAD;
            cnt       <= '0;
            stage     <= '0;
            group     <= '0;
            offset    <= '0;
            drain_cnt <= '0;
            out_last  <= 1'b0;
        end else begin
            case (state)
                LOAD: begin
                    if (load_en) begin
                        cnt <= cnt + 1'b1;
                        if (cnt_last) begin
                            state <= STAGE_ISSUE;
                        end
                    end
                end
                STAGE_ISSUE: begin
                    if (stage_last) begin
                        group  <= '0;
                        offset <= '0;
                        state  <= STAGE_DRAIN;
                    end else if (offset_last) begin
                        offset <= '0;
                        group  <= group + 1'b1;
                    end else begin
                        offset <= offset + 1'b1;
                    end
                end
                // three idle cycles until the last sums are written
                STAGE_DRAIN: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == 2'd2) begin
                        drain_cnt <= '0;
                        if (stage == fft_pkg::STAGE_W'(fft_pkg::LOG2N - 1)) begin
                            stage <= '0;
                            state <= UNLOAD_READ;
                        end else begin
                            stage <= stage + 1'b1;
                            state <= STAGE_ISSUE;
                        end
                    end
                end
                UNLOAD_READ: begin
                    out_last <= cnt_last;
                    state    <= UNLOAD_HOLD;
                end
                UNLOAD_HOLD: begin
                    if (out_ready) begin
                        out_last <= 1'b0;
                        cnt      <= cnt + 1'b1;
                        state    <= out_last ? LOAD : UNLOAD_READ;
                    end
                end
                default: state <= LOAD;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/fft_butterfly.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_butterfly (
    input  logic    clk,
    input  logic    rst_n,
    bfly_if.bfly    port
);

    // issue copy, lines up with the memory read data
    logic                                           s1_v;
    logic [fft_pkg::ADDR_W-1:0]                     s1_addr_a;
    logic [fft_pkg::ADDR_W-1:0]                     s1_addr_b;
    logic [fft_pkg::TW_IDX_W-1:0]                   s1_idx;

    fft_pkg::twiddle_t                              tw;
    logic signed [fft_pkg::DATA_W+fft_pkg::TW_W:0]  pr_re;
    logic signed [fft_pkg::DATA_W+fft_pkg::TW_W:0]  pr_im;

    // after the twiddle multiply
    logic                                           s2_v;
    logic [fft_pkg::ADDR_W-1:0]                     s2_addr_a;
    logic [fft_pkg::ADDR_W-1:0]                     s2_addr_b;
    fft_pkg::sample_t                               s2_a;
    fft_pkg::sample_t                               s2_bw;

    logic signed [fft_pkg::DATA_W:0]                sum_re;
    logic signed [fft_pkg::DATA_W:0]                sum_im;
    logic signed [fft_pkg::DATA_W:0]                dif_re;
    logic signed [fft_pkg::DATA_W:0]                dif_im;

    fft_twiddle_rom rom_inst (
        .idx (s1_idx),
        .tw  (tw)
    );

    // --------------------
    // b * w, rounded back to Q15 data
    // --------------------
    assign pr_re = port.data_b.re * tw.re - port.data_b.im * tw.im + fft_pkg::TW_ROUND;
    assign pr_im = port.data_b.re * tw.im + port.data_b.im * tw.re + fft_pkg::TW_ROUND;

    // sums one bit wider, halved on write
    assign sum_re = s2_a.re + s2_bw.re;
    assign sum_im = s2_a.im + s2_bw.im;
    assign dif_re = s2_a.re - s2_bw.re;
    assign dif_im = s2_a.im - s2_bw.im;

    // valid bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_v       <= 1'b0;
            s2_v       <= 1'b0;
            port.wr_en <= 1'b0;
        end else begin
            s1_v       <= port.rd_en && (port.addr_a != port.addr_b);
            s2_v       <= s1_v;
            port.wr_en <= s2_v;
        end
    end

    // payload and carried addresses
    always_ff @(posedge clk) begin
        s1_addr_a      <= port.addr_a;
        s1_addr_b      <= port.addr_b;
        s1_idx         <= port.tw_idx;

        s2_addr_a      <= s1_addr_a;
        s2_addr_b      <= s1_addr_b;
        s2_a           <= port.data_a;
        s2_bw.re       <= pr_re[fft_pkg::TW_FRAC +: fft_pkg::DATA_W];
        s2_bw.im       <= pr_im[fft_pkg::TW_FRAC +: fft_pkg::DATA_W];

        port.wr_addr_a <= s2_addr_a;
        port.wr_addr_b <= s2_addr_b;
        port.wr_a.re   <= sum_re[fft_pkg::DATA_W:1];
        port.wr_a.im   <= sum_im[fft_pkg::DATA_W:1];
        port.wr_b.re   <= dif_re[fft_pkg::DATA_W:1];
        port.wr_b.im   <= dif_im[fft_pkg::DATA_W:1];
    end

endmodule

`default_nettype wire

/* design/fft_twiddle_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_twiddle_rom (
    input  logic [fft_pkg::TW_IDX_W-1:0]    idx,
    output fft_pkg::twiddle_t               tw
);

    // W_16^k = cos(2*pi*k/16) - j*sin(2*pi*k/16), Q1.14 rounded
    always_comb begin
        case (idx)
            3'd0:    tw = '{re:  16'sd16384, im:  16'sd0};
            3'd1:    tw = '{re:  16'sd15137, im: -16'sd6270};
            3'd2:    tw = '{re:  16'sd11585, im: -16'sd11585};
            3'd3:    tw = '{re:  16'sd6270,  im: -16'sd15137};
            3'd4:    tw = '{re:  16'sd0,     im: -16'sd16384};
            3'd5:    tw = '{re: -16'sd6270,  im: -16'sd15137};
            3'd6:    tw = '{re: -16'sd11585, im: -16'sd11585};
            3'd7:    tw = '{re: -16'sd15137, im: -16'sd6270};
            default: tw = '{re:  16'sd16384, im:  16'sd0};
        endcase
    end

endmodule

`default_nettype wire

/* design/fft_sample_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_sample_ram (
    input  logic                        clk,
    input  logic                        rst_n,
    bfly_if.ram                         port,
    input  logic                        load_en,
    input  logic [fft_pkg::ADDR_W-1:0]  load_addr,
    input  fft_pkg::sample_t            load_data
);

    fft_pkg::sample_t mem [fft_pkg::N];

    // --------------------
    // write ports
    // --------------------
    // load and butterfly write-back are never active together
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
        if (port.wr_en) begin
            mem[port.wr_addr_a] <= port.wr_a;
            mem[port.wr_addr_b] <= port.wr_b;
        end
    end

    // --------------------
    // read ports
    // --------------------
    // data holds between reads, the unload relies on that
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            port.data_a <= '0;
            port.data_b <= '0;
        end else if (port.rd_en) begin
            port.data_a <= mem[port.addr_a];
            port.data_b <= mem[port.addr_b];
        end
    end

endmodule

`default_nettype wire

/* design/bfly_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface bfly_if;

    // issue side, driven by the controller
    // equal addresses mark a plain read with no butterfly behind it
    logic                               rd_en;
    logic [fft_pkg::ADDR_W-1:0]         addr_a;
    logic [fft_pkg::ADDR_W-1:0]         addr_b;
    logic [fft_pkg::TW_IDX_W-1:0]       tw_idx;

    // read data, one cycle after rd_en
    fft_pkg::sample_t                   data_a;
    fft_pkg::sample_t                   data_b;

    // write-back side, driven by the butterfly
    logic                               wr_en;
    logic [fft_pkg::ADDR_W-1:0]         wr_addr_a;
    logic [fft_pkg::ADDR_W-1:0]         wr_addr_b;
    fft_pkg::sample_t                   wr_a;
    fft_pkg::sample_t                   wr_b;

    modport ctrl (output rd_en, addr_a, addr_b, tw_idx);

    modport ram (
        input  rd_en, addr_a, addr_b, wr_en, wr_addr_a, wr_addr_b, wr_a, wr_b,
        output data_a, data_b
    );

    modport bfly (
        input  rd_en, addr_a, addr_b, tw_idx, data_a, data_b,
        output wr_en, wr_addr_a, wr_addr_b, wr_a, wr_b
    );

endinterface

`default_nettype wire

/* design/fft_pkg.sv */
`default_nettype none

package fft_pkg;

    // --------------------
    // transform size
    // --------------------
    localparam int N        = 16;
    localparam int LOG2N    = 4;
    localparam int ADDR_W   = 4;
    localparam int STAGE_W  = 3;
    localparam int TW_IDX_W = 3;

    // --------------------
    // fixed-point formats
    // --------------------
    localparam int DATA_W   = 16;
    // Q1.14 so that 1.0 fits exactly
    localparam int TW_W     = 16;
    localparam int TW_FRAC  = 14;
    // half an lsb of the product, for round to nearest
    localparam int TW_ROUND = 1 << (TW_FRAC - 1);

    typedef struct packed {
        logic signed [DATA_W-1:0] re;
        logic signed [DATA_W-1:0] im;
    } sample_t;

    // cos and -sin of 2*pi*k/N
    typedef struct packed {
        logic signed [TW_W-1:0] re;
        logic signed [TW_W-1:0] im;
    } twiddle_t;

endpackage

`default_nettype wire
